// ==== eth_mac_fifo_consts.svh ====
`ifndef ETH_MAC_FIFO_CONSTS_SVH
`define ETH_MAC_FIFO_CONSTS_SVH

// Stream width on both the user and the MAC side
`define ETH_DATA_WIDTH 64

// One keep bit per data byte
`define ETH_KEEP_WIDTH 8

// FIFO depths in 64-bit beats
`define TX_FIFO_DEPTH 64
`define RX_FIFO_DEPTH 64

// Register stages after the RAM output register
`define FIFO_RAM_PIPELINE 1

`endif

// ==== eth_mac_fifo_pkg.sv ====
`default_nettype none

`include "eth_mac_fifo_consts.svh"

package eth_mac_fifo_pkg;

    // One beat of a frame stream
    typedef struct packed {
        logic [`ETH_DATA_WIDTH-1:0] data;
        logic [`ETH_KEEP_WIDTH-1:0] keep;
        logic                       last;
        // Set on the last beat of a frame that must be discarded
        logic                       bad;
    } stream_beat_t;

    // Per-frame outcome, each field a single-cycle pulse
    typedef struct packed {
        logic overflow;
        logic bad_frame;
        logic good_frame;
    } fifo_status_t;

endpackage

`default_nettype wire

// ==== frame_fifo_wr.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_fifo_wr #(
    parameter int DEPTH          = 64,
    parameter bit DROP_WHEN_FULL = 1'b0
) (
    input  logic                           logic_clk,
    input  logic                           logic_rst,
    input  eth_mac_fifo_pkg::stream_beat_t in_beat,
    input  logic                           in_valid,
    output logic                           in_ready,
    output logic                           wr_en,
    output logic [$clog2(DEPTH)-1:0]       wr_addr,
    output eth_mac_fifo_pkg::stream_beat_t wr_beat,
    output logic [$clog2(DEPTH):0]         commit_ptr,
    input  logic [$clog2(DEPTH):0]         rd_ptr,
    output eth_mac_fifo_pkg::fifo_status_t status
);

    localparam int AW = $clog2(DEPTH);

    // Pointer of the frame being written, ahead of commit_ptr
    logic [AW:0] temp_ptr;
    logic        drop_frame;
    logic        full;
    logic        oversize;
    logic        in_xfer;
    logic        drop_beat;

    // No free slot left between the write head and the read side
    assign full = (temp_ptr ^ rd_ptr) == {1'b1, {AW{1'b0}}};

    // The current frame alone already spans the whole RAM
    assign oversize = (temp_ptr ^ commit_ptr) == {1'b1, {AW{1'b0}}};

    // Tx stalls on full, but keeps swallowing a frame that can never fit
    assign in_ready = DROP_WHEN_FULL || !full || oversize;

    // An oversize frame always leaves the RAM full as well
    assign in_xfer   = in_valid && in_ready;
    assign drop_beat = drop_frame || full;

    assign wr_en   = in_xfer && !drop_beat;
    assign wr_addr = temp_ptr[AW-1:0];
    assign wr_beat = in_beat;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            temp_ptr   <= '0;
            commit_ptr <= '0;
            drop_frame <= 1'b0;
            status     <= '0;
        end else begin
            status <= '0;

            if (in_xfer) begin
                if (drop_beat) begin
                    // Discard the rest of this frame
                    drop_frame <= 1'b1;
                    if (in_beat.last) begin
                        temp_ptr        <= commit_ptr;
                        drop_frame      <= 1'b0;
                        status.overflow <= 1'b1;
                    end
                end else begin
                    temp_ptr <= temp_ptr + (AW+1)'(1);
                    if (in_beat.last) begin
                        if (in_beat.bad) begin
                            // Roll back over the whole frame
                            temp_ptr         <= commit_ptr;
                            status.bad_frame <= 1'b1;
                        end else begin
                            // Frame becomes visible to the reader next cycle
                            commit_ptr        <= temp_ptr + (AW+1)'(1);
                            status.good_frame <= 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== frame_fifo_rd.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "eth_mac_fifo_consts.svh"

module frame_fifo_rd #(
    parameter int DEPTH = 64
) (
    input  logic                           logic_clk,
    input  logic                           logic_rst,
    input  logic [$clog2(DEPTH):0]         commit_ptr,
    output logic [$clog2(DEPTH):0]         rd_ptr,
    output logic [$clog2(DEPTH)-1:0]       rd_addr,
    input  eth_mac_fifo_pkg::stream_beat_t rd_data,
    output eth_mac_fifo_pkg::stream_beat_t out_beat,
    output logic                           out_valid,
    input  logic                           out_ready
);

    import eth_mac_fifo_pkg::*;

    localparam int AW        = $clog2(DEPTH);
    localparam int PIPE      = `FIFO_RAM_PIPELINE;
    localparam int BW        = $clog2(PIPE + 2);
    localparam int BUF_DEPTH = 2 ** BW;

    // v_q[0] tags the RAM output register, v_q[k] pipeline stage k-1
    logic [PIPE:0] v_q;
    stream_beat_t  pipe_q [PIPE];
    // Output buffer, large enough to cover the read round trip
    stream_beat_t  obuf_q [BUF_DEPTH];
    logic [BW-1:0] head_q;
    logic [BW-1:0] tail_q;
    logic [BW:0]   cnt_q;
    stream_beat_t  push_beat;
    logic          push;
    logic          pop;
    logic          pending;
    logic          issue;

    assign pending   = rd_ptr != commit_ptr;
    assign push      = v_q[PIPE];
    assign out_valid = cnt_q != '0;
    assign pop       = out_valid && out_ready;
    assign out_beat  = obuf_q[head_q];
    assign rd_addr   = rd_ptr[AW-1:0];

    // Read only when every beat in flight still finds a buffer slot
    always_comb begin
        issue = pending && (int'(cnt_q) + $countones(v_q) - int'(pop) < BUF_DEPTH);
    end

    // The bad flag never leaves the FIFO
    always_comb begin
        push_beat     = pipe_q[PIPE-1];
        push_beat.bad = 1'b0;
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            rd_ptr <= '0;
            v_q    <= '0;
            head_q <= '0;
            tail_q <= '0;
            cnt_q  <= '0;
        end else begin
            if (issue) begin
                rd_ptr <= rd_ptr + (AW+1)'(1);
            end
            v_q <= {v_q[PIPE-1:0], issue};

            if (push) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop) begin
                head_q <= head_q + 1'b1;
            end

            case ({push, pop})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    // Pipeline stages shift every cycle, the credit check prevents loss
    always_ff @(posedge logic_clk) begin
        pipe_q[0] <= rd_data;
        for (int k = 1; k < PIPE; k++) begin
            pipe_q[k] <= pipe_q[k-1];
        end
        if (push) begin
            obuf_q[tail_q] <= push_beat;
        end
    end

endmodule

`default_nettype wire

// ==== frame_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_fifo #(
    parameter int DEPTH          = 64,
    parameter bit DROP_WHEN_FULL = 1'b0
) (
    input  logic                           logic_clk,
    input  logic                           logic_rst,
    input  eth_mac_fifo_pkg::stream_beat_t in_beat,
    input  logic                           in_valid,
    output logic                           in_ready,
    output eth_mac_fifo_pkg::stream_beat_t out_beat,
    output logic                           out_valid,
    input  logic                           out_ready,
    output eth_mac_fifo_pkg::fifo_status_t status
);

    import eth_mac_fifo_pkg::*;

    localparam int AW = $clog2(DEPTH);

    // Beat storage, one write port and one registered read port
    stream_beat_t mem [DEPTH];

    stream_beat_t wr_beat;
    stream_beat_t rd_data;
    logic         wr_en;
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] rd_addr;
    logic [AW:0]   commit_ptr;
    logic [AW:0]   rd_ptr;

    always_ff @(posedge logic_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat;
        end
        rd_data <= mem[rd_addr];
    end

    frame_fifo_wr #(
        .DEPTH          (DEPTH),
        .DROP_WHEN_FULL (DROP_WHEN_FULL)
    ) u_wr (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .in_beat    (in_beat),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_beat    (wr_beat),
        .commit_ptr (commit_ptr),
        .rd_ptr     (rd_ptr),
        .status     (status)
    );

    frame_fifo_rd #(
        .DEPTH (DEPTH)
    ) u_rd (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .commit_ptr (commit_ptr),
        .rd_ptr     (rd_ptr),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

// ==== eth_mac_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "eth_mac_fifo_consts.svh"

module eth_mac_fifo (
    input  logic                           logic_clk,
    input  logic                           logic_rst,

    // User transmit stream
    input  eth_mac_fifo_pkg::stream_beat_t tx_axis_beat,
    input  logic                           tx_axis_valid,
    output logic                           tx_axis_ready,

    // Toward the MAC transmit side
    output eth_mac_fifo_pkg::stream_beat_t mac_tx_beat,
    output logic                           mac_tx_valid,
    input  logic                           mac_tx_ready,

    // From the MAC receive side, which cannot be stalled
    input  eth_mac_fifo_pkg::stream_beat_t mac_rx_beat,
    input  logic                           mac_rx_valid,

    // User receive stream
    output eth_mac_fifo_pkg::stream_beat_t rx_axis_beat,
    output logic                           rx_axis_valid,
    input  logic                           rx_axis_ready,

    output eth_mac_fifo_pkg::fifo_status_t tx_fifo_status,
    output eth_mac_fifo_pkg::fifo_status_t rx_fifo_status
);

    // Tx waits on a full FIFO, only oversize and bad frames are lost
    frame_fifo #(
        .DEPTH          (`TX_FIFO_DEPTH),
        .DROP_WHEN_FULL (1'b0)
    ) tx_fifo (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .in_beat   (tx_axis_beat),
        .in_valid  (tx_axis_valid),
        .in_ready  (tx_axis_ready),
        .out_beat  (mac_tx_beat),
        .out_valid (mac_tx_valid),
        .out_ready (mac_tx_ready),
        .status    (tx_fifo_status)
    );

    // Rx drops whatever does not fit
    frame_fifo #(
        .DEPTH          (`RX_FIFO_DEPTH),
        .DROP_WHEN_FULL (1'b1)
    ) rx_fifo (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .in_beat   (mac_rx_beat),
        .in_valid  (mac_rx_valid),
        .in_ready  (),
        .out_beat  (rx_axis_beat),
        .out_valid (rx_axis_valid),
        .out_ready (rx_axis_ready),
        .status    (rx_fifo_status)
    );

endmodule

`default_nettype wire

// ==== eth_mac_fifo_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module eth_mac_fifo_checker (
    input logic                           logic_clk,
    input logic                           logic_rst,
    input eth_mac_fifo_pkg::stream_beat_t mac_tx_beat,
    input logic                           mac_tx_valid,
    input logic                           mac_tx_ready,
    input eth_mac_fifo_pkg::stream_beat_t rx_axis_beat,
    input logic                           rx_axis_valid,
    input logic                           rx_axis_ready,
    input eth_mac_fifo_pkg::fifo_status_t tx_fifo_status,
    input eth_mac_fifo_pkg::fifo_status_t rx_fifo_status
);

    // A stalled beat stays on the bus unchanged
    mac_tx_hold: assert property (@(posedge logic_clk) disable iff (logic_rst)
        (mac_tx_valid && !mac_tx_ready) |=> (mac_tx_valid && $stable(mac_tx_beat)))
        else $error("mac_tx beat changed while stalled");

    rx_axis_hold: assert property (@(posedge logic_clk) disable iff (logic_rst)
        (rx_axis_valid && !rx_axis_ready) |=> (rx_axis_valid && $stable(rx_axis_beat)))
        else $error("rx_axis beat changed while stalled");

    // One outcome per frame
    tx_status_excl: assert property (@(posedge logic_clk) disable iff (logic_rst)
        $onehot0(tx_fifo_status))
        else $error("tx_fifo_status pulses overlap");

    rx_status_excl: assert property (@(posedge logic_clk) disable iff (logic_rst)
        $onehot0(rx_fifo_status))
        else $error("rx_fifo_status pulses overlap");

endmodule

bind eth_mac_fifo eth_mac_fifo_checker chk_i (.*);

`default_nettype wire

// ==== tb_eth_mac_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "eth_mac_fifo_consts.svh"

module tb_eth_mac_fifo;

    import eth_mac_fifo_pkg::*;

    localparam int TIMEOUT = 2000;

    logic           logic_clk;
    logic           logic_rst;
    stream_beat_t   tx_axis_beat;
    logic           tx_axis_valid;
    logic           tx_axis_ready;
    stream_beat_t   mac_tx_beat;
    logic           mac_tx_valid;
    logic           mac_tx_ready;
    stream_beat_t   mac_rx_beat;
    logic           mac_rx_valid;
    stream_beat_t   rx_axis_beat;
    logic           rx_axis_valid;
    logic           rx_axis_ready;
    fifo_status_t   tx_fifo_status;
    fifo_status_t   rx_fifo_status;

    int             seed;
    int             errors;
    int             tests_passed;
    int             tests_failed;
    int             path;
    int             mode;
    int             nframes;
    int             lens [4];
    int             bads [4];
    int             exp_cnt [3];
    int             cnt_good;
    int             cnt_bad;
    int             cnt_ovf;
    bit             collect_done;
    bit             drive_done;
    stream_beat_t   send_q [$];
    stream_beat_t   exp_q [$];

    eth_mac_fifo dut_i (.*);

    initial begin
        logic_clk = 1'b0;
        forever #5 logic_clk = ~logic_clk;
    end

    // Status pulses of the path under test
    always @(posedge logic_clk) begin
        if (!logic_rst) begin
            cnt_good += int'(path == 0 ? tx_fifo_status.good_frame : rx_fifo_status.good_frame);
            cnt_bad  += int'(path == 0 ? tx_fifo_status.bad_frame : rx_fifo_status.bad_frame);
            cnt_ovf  += int'(path == 0 ? tx_fifo_status.overflow : rx_fifo_status.overflow);
        end
    end

    task automatic check_beat(string name, stream_beat_t got, stream_beat_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_status(string name, fifo_status_t got, fifo_status_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic set_ready(logic v);
        if (path == 0) begin
            mac_tx_ready = v;
        end else begin
            rx_axis_ready = v;
        end
    endtask

    // Frames and the expected output by the frame rules
    task automatic build_frames();
        stream_beat_t beat;
        stream_beat_t frame_q [$];
        int           occ;
        int           depth;
        int           model [3];
        bit           pass;
        occ   = 0;
        depth = path == 0 ? `TX_FIFO_DEPTH : `RX_FIFO_DEPTH;
        model = '{0, 0, 0};
        for (int f = 0; f < nframes; f++) begin
            frame_q.delete();
            for (int b = 0; b < lens[f]; b++) begin
                beat.data = {$random(seed), $random(seed)};
                beat.last = b == lens[f] - 1;
                beat.keep = beat.last ? 8'hff >> ($random(seed) & 7) : 8'hff;
                beat.bad  = beat.last && bads[f] != 0;
                send_q.push_back(beat);
                beat.bad = 1'b0;
                frame_q.push_back(beat);
            end
            pass = 1'b0;
            if (bads[f] != 0) begin
                model[1]++;
            end else if (lens[f] > depth || (path == 1 && mode == 1 && occ + lens[f] > depth)) begin
                model[2]++;
            end else begin
                model[0]++;
                pass = 1'b1;
                occ += lens[f];
            end
            if (pass) begin
                foreach (frame_q[i]) exp_q.push_back(frame_q[i]);
            end
        end
        check_count("model good_frame count", model[0], exp_cnt[0]);
        check_count("model bad_frame count", model[1], exp_cnt[1]);
        check_count("model overflow count", model[2], exp_cnt[2]);
    endtask

    task automatic drive_frames();
        int wait_cnt;
        for (int i = 0; i < send_q.size(); i++) begin
            @(negedge logic_clk);
            if (path == 0) begin
                tx_axis_beat  = send_q[i];
                tx_axis_valid = 1'b1;
                wait_cnt = 0;
                while (!tx_axis_ready && wait_cnt < TIMEOUT) begin
                    @(negedge logic_clk);
                    wait_cnt++;
                end
                if (wait_cnt >= TIMEOUT) begin
                    $display("Timeout waiting for tx_axis_ready");
                    errors++;
                    break;
                end
            end else begin
                mac_rx_beat  = send_q[i];
                mac_rx_valid = 1'b1;
            end
        end
        @(negedge logic_clk);
        tx_axis_valid = 1'b0;
        mac_rx_valid  = 1'b0;
        drive_done    = 1'b1;
    endtask

    task automatic collect_frames();
        stream_beat_t got;
        stream_beat_t exp;
        int           idle;
        idle = 0;
        while (exp_q.size() > 0 && idle < TIMEOUT) begin
            @(posedge logic_clk);
            if (path == 0 && mac_tx_valid && mac_tx_ready) begin
                got  = mac_tx_beat;
                exp  = exp_q.pop_front();
                check_beat("mac_tx_beat", got, exp);
                idle = 0;
            end else if (path == 1 && rx_axis_valid && rx_axis_ready) begin
                got  = rx_axis_beat;
                exp  = exp_q.pop_front();
                check_beat("rx_axis_beat", got, exp);
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (exp_q.size() > 0) begin
            $display("Timeout with %0d expected beats never delivered", exp_q.size());
            errors++;
        end
        collect_done = 1'b1;
    endtask

    task automatic drive_ready();
        bit stalled;
        int cycles;
        stalled = 1'b0;
        cycles  = 0;
        @(negedge logic_clk);
        set_ready(mode != 1);
        if (mode == 1) begin
            // Tx holds until the input stalls, rx until every frame is sent
            while (!stalled && cycles < TIMEOUT) begin
                @(negedge logic_clk);
                stalled = path == 0 ? !tx_axis_ready : drive_done;
                cycles++;
            end
            if (!stalled) begin
                $display("Timeout waiting for the %s FIFO to fill", path == 0 ? "tx" : "rx");
                errors++;
            end
            set_ready(1'b1);
        end else if (mode == 2) begin
            while (!collect_done && cycles < TIMEOUT * 4) begin
                @(negedge logic_clk);
                set_ready(1'($random(seed) & 1));
                cycles++;
            end
            set_ready(1'b1);
        end
    endtask

    task automatic run_test(int num);
        int err0;
        err0 = errors;
        send_q.delete();
        exp_q.delete();
        @(negedge logic_clk);
        cnt_good     = 0;
        cnt_bad      = 0;
        cnt_ovf      = 0;
        collect_done = 1'b0;
        drive_done   = 1'b0;
        build_frames();
        fork
            drive_frames();
            collect_frames();
            drive_ready();
        join
        repeat (20) @(negedge logic_clk);
        check_bit(path == 0 ? "mac_tx_valid" : "rx_axis_valid",
                  path == 0 ? mac_tx_valid : rx_axis_valid, 1'b0);
        check_count("good_frame count", cnt_good, exp_cnt[0]);
        check_count("bad_frame count", cnt_bad, exp_cnt[1]);
        check_count("overflow count", cnt_ovf, exp_cnt[2]);
        if (errors == err0) begin
            tests_passed++;
            $display("test %0d %s mode %0d frames %0d ok", num, path == 0 ? "tx" : "rx",
                     mode, nframes);
        end else begin
            tests_failed++;
            $display("test %0d %s mode %0d frames %0d failed", num, path == 0 ? "tx" : "rx",
                     mode, nframes);
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    num;
        string line;
        seed          = 32'h5e25_0309;
        errors        = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        num           = 0;
        path          = 0;
        mode          = 0;
        logic_rst     = 1'b1;
        tx_axis_beat  = '0;
        tx_axis_valid = 1'b0;
        mac_tx_ready  = 1'b1;
        mac_rx_beat   = '0;
        mac_rx_valid  = 1'b0;
        rx_axis_ready = 1'b1;
        repeat (16) @(posedge logic_clk);
        @(negedge logic_clk);
        logic_rst = 1'b0;

        @(negedge logic_clk);
        check_bit("mac_tx_valid", mac_tx_valid, 1'b0);
        check_bit("rx_axis_valid", rx_axis_valid, 1'b0);
        check_bit("tx_axis_ready", tx_axis_ready, 1'b1);
        check_status("tx_fifo_status", tx_fifo_status, '0);
        check_status("rx_fifo_status", rx_fifo_status, '0);

        fd = $fopen("eth_mac_fifo_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != 8'h23) begin
                    n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                                path, nframes, mode, lens[0], lens[1], lens[2], lens[3],
                                bads[0], bads[1], bads[2], bads[3],
                                exp_cnt[0], exp_cnt[1], exp_cnt[2]);
                    if (n == 14) begin
                        num++;
                        run_test(num);
                    end
                end
            end
            $fclose(fd);
        end
        if (num == 0) begin
            $display("No test was read from the stimulus file");
            errors++;
        end

        $display("tests %0d passed %0d failed %0d errors %0d", num, tests_passed,
                 tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== eth_mac_fifo_stimulus.txt ====
# One test per line, fields separated by spaces
# path (0 tx, 1 rx) frames ready_mode (0 high, 1 held low then released, 2 random)
# len0 len1 len2 len3 bad0 bad1 bad2 bad3 exp_good exp_bad exp_overflow
#
# Good tx frames of several lengths
0 4 0 1 3 8 17 0 0 0 0 4 0 0
# Tx frame marked bad between two good ones
0 3 0 5 9 6 0 0 1 0 0 2 1 0
# Good rx frames
1 3 0 2 11 4 0 0 0 0 0 3 0 0
# Rx frame longer than the FIFO, then a good one
1 2 0 70 12 0 0 0 0 0 0 1 0 1
# Rx frames fill the FIFO while the user stalls, the third one is dropped
1 3 1 30 30 20 0 0 0 0 0 2 0 1
# Tx back-pressure with more beats than the FIFO holds
0 3 1 30 30 30 0 0 0 0 0 3 0 0
# Rx with a randomly toggled ready
1 4 2 10 20 15 8 0 0 0 0 4 0 0
# Tx with a randomly toggled ready
0 4 2 7 1 16 12 0 0 0 0 4 0 0

// ==== compile.f ====
+incdir+.
eth_mac_fifo_pkg.sv
frame_fifo_wr.sv
frame_fifo_rd.sv
frame_fifo.sv
eth_mac_fifo.sv
eth_mac_fifo_checker.sv
tb_eth_mac_fifo.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_eth_mac_fifo
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FILELIST  := compile.f
SRCS      := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS      := eth_mac_fifo_consts.svh
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM) eth_mac_fifo_stimulus.txt
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "Run failed"; exit 1; \
	elif ! grep -q "Simulation PASSED" $(LOG); then \
		echo "Run ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
